//--- all.f
design/er_pkg.sv
design/er_fsm.sv
design/er_step_counter.sv
design/er_fifo_channel.sv
design/reconciled_key_writer.sv
design/single_frame_er.sv
test/tb_single_frame_er.sv

//--- test/tb_single_frame_er.sv
`timescale 1ns/100ps

module tb_single_frame_er
    import er_pkg::*;
();

    localparam int wait_limit = 400;

    logic           clk = 1'b0;
    logic           rst_n, start;
    logic           cascade_start, cascade_params_valid, cascade_done;
    error_count_t   cascade_error_count, er_error_count;
    leaked_info_t   cascade_leaked_info, er_leaked_info;
    corrected_key_t corrected_key;
    logic           cascade_b2a_rd_en, cascade_a2b_wr_en;
    fifo_word_t     cascade_a2b_wr_din, cascade_b2a_rd_dout, b2a_rd_dout, a2b_wr_din;
    logic           cascade_b2a_rd_valid, cascade_b2a_empty, cascade_a2b_full;
    logic           hash_start, hash_valid;
    hashtag_t       hash_tag;
    logic           b2a_rd_valid, b2a_empty, b2a_rd_en, a2b_full, a2b_wr_en;
    key_addr_t      key_addr;
    key_word_t      key_din;
    logic           key_we, er_parameter_valid, finish, fail;

    // current frame
    corrected_key_t frame_key;
    hashtag_t       frame_tag;
    error_count_t   frame_err;
    leaked_info_t   frame_leak;
    logic           frame_match;
    int             params_lat, done_lat, hash_lat, full_hold;

    fifo_word_t     b2a_q[$];
    fifo_word_t     sent_q[$];
    key_addr_t      addr_q[$];
    key_word_t      data_q[$];
    int             read_count = 0;
    logic           window_open, done_tail, owned, rd_req, push_req;
    key_addr_t      next_addr = '0;

    single_frame_er u_single_frame_er (.*);

    always #20 clk = ~clk;

    task automatic stop_with_fail();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
        stop_with_fail();
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else report_mismatch(name, exp, act);
    endtask

    task automatic advance_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // cascade engine starts three cycles after a start request
    assert property (@(posedge clk) disable iff (!rst_n) start |-> ##3 cascade_start)
        else begin
            $display("[FAIL] %0t ns cascade_start expected 1 actual 0", $time);
            stop_with_fail();
        end

    assert property (@(posedge clk) disable iff (!rst_n) er_parameter_valid == finish)
        else begin
            $display("[FAIL] %0t ns er_parameter_valid expected %0b actual %0b", $time,
                     $sampled(finish), $sampled(er_parameter_valid));
            stop_with_fail();
        end

    // cascade and hash engines, and the a2b full flag
    initial begin : engine_model
        int cycles;
        cascade_params_valid = 1'b0;
        cascade_error_count = '0;
        cascade_leaked_info = '0;
        cascade_done = 1'b0;
        corrected_key = '0;
        hash_valid = 1'b0;
        hash_tag = '0;
        a2b_full = 1'b0;
        forever begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
            end while (cascade_start !== 1'b1 && cycles < 1000);
            if (cascade_start !== 1'b1) begin
                $display("cascade engine model never saw cascade_start");
                stop_with_fail();
            end
            advance_cycles(1);
            a2b_full = 1'b1;
            advance_cycles(params_lat);
            cascade_params_valid = 1'b1;
            cascade_error_count = frame_err;
            cascade_leaked_info = frame_leak;
            advance_cycles(1);
            cascade_params_valid = 1'b0;
            advance_cycles(done_lat);
            corrected_key = frame_key;
            cascade_done = 1'b1;
            advance_cycles(1);
            cascade_done = 1'b0;
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
            end while (hash_start !== 1'b1 && cycles < wait_limit);
            if (hash_start !== 1'b1) begin
                $display("hash engine model never saw hash_start");
                stop_with_fail();
            end
            advance_cycles(hash_lat);
            hash_valid = 1'b1;
            hash_tag = frame_tag;
            advance_cycles(1);
            hash_valid = 1'b0;
            // a2b fifo drains a while after the tag is ready
            advance_cycles(full_hold);
            a2b_full = 1'b0;
        end
    end

    // b2a fifo holding bob's packet, plus the cascade's own fifo requests
    initial begin
        b2a_empty = 1'b1;
        b2a_rd_dout = '0;
        b2a_rd_valid = 1'b0;
        cascade_b2a_rd_en = 1'b0;
        cascade_a2b_wr_en = 1'b0;
        cascade_a2b_wr_din = '0;
        forever begin
            @(negedge clk);
            rd_req = b2a_rd_en;
            push_req = hash_start;
            advance_cycles(1);
            // header first, which alice ignores
            if (push_req === 1'b1) begin
                b2a_q.push_back($urandom);
                b2a_q.push_back(frame_match ? frame_tag[63:32] : ~frame_tag[63:32]);
            end
            // every read returns a word, random while bob's packet is absent
            b2a_rd_valid = (rd_req === 1'b1);
            if (b2a_rd_valid && b2a_q.size() > 0) begin
                b2a_rd_dout = b2a_q.pop_front();
            end else if (b2a_rd_valid) begin
                b2a_rd_dout = $urandom;
            end
            b2a_empty = (b2a_q.size() == 0);
            // requests toggle inside and outside the cascade window
            cascade_b2a_rd_en = 1'($urandom);
            cascade_a2b_wr_en = 1'($urandom);
            cascade_a2b_wr_din = $urandom;
        end
    end

    // fifo ownership and traffic seen at the dut ports
    always @(negedge clk) begin
        if (!rst_n) begin
            window_open = 1'b0;
            done_tail = 1'b0;
        end else begin
            owned = cascade_start || window_open;
            if (owned) begin
                check_value("b2a_rd_en", cascade_b2a_rd_en, b2a_rd_en);
                check_value("a2b_wr_en", cascade_a2b_wr_en, a2b_wr_en);
                check_value("a2b_wr_din", cascade_a2b_wr_din, a2b_wr_din);
                check_value("cascade_b2a_rd_dout", b2a_rd_dout, cascade_b2a_rd_dout);
                check_value("cascade_b2a_rd_valid", b2a_rd_valid, cascade_b2a_rd_valid);
                check_value("cascade_b2a_empty", b2a_empty, cascade_b2a_empty);
                check_value("cascade_a2b_full", a2b_full, cascade_a2b_full);
            end else begin
                check_value("cascade_b2a_rd_dout", 0, cascade_b2a_rd_dout);
                check_value("cascade_b2a_rd_valid", 0, cascade_b2a_rd_valid);
                check_value("cascade_b2a_empty", 0, cascade_b2a_empty);
                check_value("cascade_a2b_full", 0, cascade_a2b_full);
                if (b2a_rd_en) begin
                    read_count++;
                    if (a2b_full) begin
                        $display("B2A read started while the A2B FIFO was full");
                        stop_with_fail();
                    end
                end
                if (a2b_wr_en) begin
                    sent_q.push_back(a2b_wr_din);
                end
            end
            if (key_we) begin
                addr_q.push_back(key_addr);
                data_q.push_back(key_din);
            end
            // window runs from cascade_start to one cycle past cascade_done
            if (cascade_start) begin
                window_open = 1'b1;
            end else if (done_tail) begin
                window_open = 1'b0;
                done_tail = 1'b0;
            end else if (cascade_done) begin
                done_tail = 1'b1;
            end
        end
    end

    task automatic run_frame(input logic match);
        int i;
        int cycles;
        int reads_before;
        int sent_before;
        int writes_before;
        int n_writes;
        for (i = 0; i < key_words * 2; i++) begin
            frame_key[i*32 +: 32] = $urandom;
        end
        frame_tag = {$urandom, $urandom};
        frame_err = error_count_t'($urandom);
        frame_leak = leaked_info_t'($urandom);
        frame_match = match;
        params_lat = 1 + $urandom % 12;
        done_lat = 1 + $urandom % 8;
        hash_lat = 1 + $urandom % 10;
        // long enough that the read would start while still full
        full_hold = 4 + $urandom % 6;
        reads_before = read_count;
        sent_before = sent_q.size();
        writes_before = addr_q.size();
        advance_cycles(1);
        start = 1'b1;
        advance_cycles(1);
        start = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (finish !== 1'b1 && cycles < wait_limit);
        if (finish !== 1'b1) begin
            $display("finish did not pulse within %0d cycles of start", wait_limit);
            stop_with_fail();
        end
        check_value("fail", !match, fail);
        check_value("er_error_count", frame_err, er_error_count);
        check_value("er_leaked_info", frame_leak, er_leaked_info);
        check_value("b2a_rd_en count", 2, read_count - reads_before);
        check_value("a2b_wr_en count", 3, sent_q.size() - sent_before);
        check_value("a2b header", {pkt_type_target_hashtag, pkt_len_code, tag_pkt_depth, 15'b0},
                    sent_q[sent_before]);
        check_value("a2b tag", frame_tag[63:32], sent_q[sent_before + 1]);
        check_value("a2b error count", {20'b0, frame_err}, sent_q[sent_before + 2]);
        n_writes = match ? key_words : 0;
        check_value("key_we count", n_writes, addr_q.size() - writes_before);
        // highest word goes to the lowest address
        for (i = 0; i < n_writes; i++) begin
            check_value("key_addr", next_addr + key_addr_t'(i), addr_q[writes_before + i]);
            check_value("key_din", frame_key[(key_words - 1 - i)*key_word_w +: key_word_w],
                        data_q[writes_before + i]);
        end
        next_addr = next_addr + key_addr_t'(n_writes);
    endtask

    initial begin
        void'($urandom(6729));
        rst_n = 1'b0;
        start = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("er_error_count", 12'd250, er_error_count);
        check_value("er_leaked_info", 0, er_leaked_info);
        check_value("key_addr", {key_addr_w{1'b1}}, key_addr);
        check_value("key_we", 0, key_we);
        check_value("cascade_start", 0, cascade_start);
        check_value("hash_start", 0, hash_start);
        check_value("finish", 0, finish);
        run_frame(1'b1);
        run_frame(1'b0);
        run_frame(1'b1);
        $display("test passed");
        $finish;
    end

endmodule

//--- design/single_frame_er.sv
`timescale 1ns/100ps

module single_frame_er
    import er_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    output logic           cascade_start,
    input  logic           cascade_params_valid,
    input  error_count_t   cascade_error_count,
    input  leaked_info_t   cascade_leaked_info,
    input  logic           cascade_done,
    input  corrected_key_t corrected_key,
    input  logic           cascade_b2a_rd_en,
    input  logic           cascade_a2b_wr_en,
    input  fifo_word_t     cascade_a2b_wr_din,
    output fifo_word_t     cascade_b2a_rd_dout,
    output logic           cascade_b2a_rd_valid,
    output logic           cascade_b2a_empty,
    output logic           cascade_a2b_full,
    output logic           hash_start,
    input  logic           hash_valid,
    input  hashtag_t       hash_tag,
    input  fifo_word_t     b2a_rd_dout,
    input  logic           b2a_rd_valid,
    input  logic           b2a_empty,
    output logic           b2a_rd_en,
    input  logic           a2b_full,
    output logic           a2b_wr_en,
    output fifo_word_t     a2b_wr_din,
    output key_addr_t      key_addr,
    output key_word_t      key_din,
    output logic           key_we,
    output error_count_t   er_error_count,
    output leaked_info_t   er_leaked_info,
    output logic           er_parameter_valid,
    output logic           finish,
    output logic           fail
);

    logic      clear;
    logic      ec_owns_fifo;
    logic      step_done;
    logic      tags_match;
    er_phase_t phase;
    step_t     step;

    er_fsm u_er_fsm (
        .clk(clk), .rst_n(rst_n), .start(start),
        .cascade_params_valid(cascade_params_valid), .cascade_done(cascade_done),
        .hash_valid(hash_valid), .b2a_empty(b2a_empty), .a2b_full(a2b_full),
        .step_done(step_done), .tags_match(tags_match),
        .clear(clear), .cascade_start(cascade_start), .hash_start(hash_start),
        .ec_owns_fifo(ec_owns_fifo), .finish(finish), .fail(fail),
        .er_parameter_valid(er_parameter_valid), .phase(phase)
    );

    er_step_counter u_er_step_counter (
        .clk(clk), .rst_n(rst_n), .clear(clear), .phase(phase),
        .step(step), .step_done(step_done)
    );

    er_fifo_channel u_er_fifo_channel (
        .clk(clk), .rst_n(rst_n), .clear(clear), .ec_owns_fifo(ec_owns_fifo),
        .phase(phase), .step(step),
        .cascade_params_valid(cascade_params_valid),
        .cascade_error_count(cascade_error_count),
        .cascade_leaked_info(cascade_leaked_info),
        .cascade_b2a_rd_en(cascade_b2a_rd_en), .cascade_a2b_wr_en(cascade_a2b_wr_en),
        .cascade_a2b_wr_din(cascade_a2b_wr_din), .cascade_b2a_rd_dout(cascade_b2a_rd_dout),
        .cascade_b2a_rd_valid(cascade_b2a_rd_valid), .cascade_b2a_empty(cascade_b2a_empty),
        .cascade_a2b_full(cascade_a2b_full),
        .hash_valid(hash_valid), .hash_tag(hash_tag),
        .b2a_rd_dout(b2a_rd_dout), .b2a_rd_valid(b2a_rd_valid), .b2a_empty(b2a_empty),
        .a2b_full(a2b_full), .b2a_rd_en(b2a_rd_en), .a2b_wr_en(a2b_wr_en),
        .a2b_wr_din(a2b_wr_din), .tags_match(tags_match),
        .er_error_count(er_error_count), .er_leaked_info(er_leaked_info)
    );

    reconciled_key_writer u_reconciled_key_writer (
        .clk(clk), .rst_n(rst_n), .phase(phase), .step(step),
        .corrected_key(corrected_key),
        .key_addr(key_addr), .key_din(key_din), .key_we(key_we)
    );

endmodule

//--- design/reconciled_key_writer.sv
`timescale 1ns/100ps

module reconciled_key_writer
    import er_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  er_phase_t      phase,
    input  step_t          step,
    input  corrected_key_t corrected_key,
    output key_addr_t      key_addr,
    output key_word_t      key_din,
    output logic           key_we
);

    logic write_step;
    int   word_idx;

    // steps 1 to key_words each carry one word
    assign write_step = (phase == PHASE_WRITE) && (step >= 1) && (step <= key_words);

    // highest word first
    assign word_idx = key_words - int'(step);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_we <= 1'b0;
        end else begin
            key_we <= write_step;
        end
    end

    // all ones so the first write wraps to address 0
    // not touched by clear, frames continue in memory
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_addr <= '1;
        end else if (write_step) begin
            key_addr <= key_addr + key_addr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (write_step) begin
            key_din <= corrected_key[word_idx*key_word_w +: key_word_w];
        end
    end

endmodule

//--- design/er_fifo_channel.sv
`timescale 1ns/100ps

module er_fifo_channel
    import er_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         clear,
    input  logic         ec_owns_fifo,
    input  er_phase_t    phase,
    input  step_t        step,
    input  logic         cascade_params_valid,
    input  error_count_t cascade_error_count,
    input  leaked_info_t cascade_leaked_info,
    input  logic         cascade_b2a_rd_en,
    input  logic         cascade_a2b_wr_en,
    input  fifo_word_t   cascade_a2b_wr_din,
    output fifo_word_t   cascade_b2a_rd_dout,
    output logic         cascade_b2a_rd_valid,
    output logic         cascade_b2a_empty,
    output logic         cascade_a2b_full,
    input  logic         hash_valid,
    input  hashtag_t     hash_tag,
    input  fifo_word_t   b2a_rd_dout,
    input  logic         b2a_rd_valid,
    input  logic         b2a_empty,
    input  logic         a2b_full,
    output logic         b2a_rd_en,
    output logic         a2b_wr_en,
    output fifo_word_t   a2b_wr_din,
    output logic         tags_match,
    output error_count_t er_error_count,
    output leaked_info_t er_leaked_info
);

    hashtag_t   alice_tag;
    peer_tag_t  bob_tag;
    logic       reading;
    logic       sending;
    logic       own_rd_en;
    logic       own_wr_en;
    fifo_word_t own_wr_din;

    assign reading = (phase == PHASE_READ);
    assign sending = (phase == PHASE_SEND);

    // header at step 1, tag at step 2
    assign own_rd_en = reading && (step >= 1) && (step <= 2);
    assign own_wr_en = sending && (step >= 1) && (step <= 3);

    always_comb begin
        own_wr_din = '0;
        if (sending) begin
            case (step)
                1: own_wr_din = {pkt_type_target_hashtag, pkt_len_code, tag_pkt_depth, 15'b0};
                2: own_wr_din = alice_tag[hashtag_w-1 -: peer_tag_w];
                3: own_wr_din = {{(fifo_word_w - error_count_w){1'b0}}, er_error_count};
                default: own_wr_din = '0;
            endcase
        end
    end

    // fifo ports go to whoever owns them
    assign b2a_rd_en = ec_owns_fifo ? cascade_b2a_rd_en : own_rd_en;
    assign a2b_wr_en = ec_owns_fifo ? cascade_a2b_wr_en : own_wr_en;
    assign a2b_wr_din = ec_owns_fifo ? cascade_a2b_wr_din : own_wr_din;

    // cascade sees an idle fifo outside its window
    assign cascade_b2a_rd_dout = ec_owns_fifo ? b2a_rd_dout : '0;
    assign cascade_b2a_rd_valid = ec_owns_fifo ? b2a_rd_valid : 1'b0;
    assign cascade_b2a_empty = ec_owns_fifo ? b2a_empty : 1'b0;
    assign cascade_a2b_full = ec_owns_fifo ? a2b_full : 1'b0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            er_error_count <= default_error_count;
            er_leaked_info <= '0;
        end else if (cascade_params_valid) begin
            er_error_count <= cascade_error_count;
            er_leaked_info <= cascade_leaked_info;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            alice_tag <= '0;
        end else if (hash_valid) begin
            alice_tag <= hash_tag;
        end
    end

    // word requested at step 2 lands at step 3
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            bob_tag <= '0;
        end else if (reading && step == 3) begin
            bob_tag <= b2a_rd_dout;
        end
    end

    // only the upper half goes over the link
    assign tags_match = (alice_tag[hashtag_w-1 -: peer_tag_w] == bob_tag);

endmodule

//--- design/er_step_counter.sv
`timescale 1ns/100ps

module er_step_counter
    import er_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      clear,
    input  er_phase_t phase,
    output step_t     step,
    output logic      step_done
);

    step_t end_step;

    // terminal count of the running phase
    always_comb begin
        case (phase)
            PHASE_READ:  end_step = read_end_step;
            PHASE_SEND:  end_step = send_end_step;
            PHASE_WRITE: end_step = write_end_step;
            default:     end_step = '0;
        endcase
    end

    assign step_done = (phase != PHASE_IDLE) && (step == end_step);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step <= '0;
        end else if (clear || phase == PHASE_IDLE || step_done) begin
            // next phase starts again from zero
            step <= '0;
        end else begin
            step <= step + step_t'(1);
        end
    end

endmodule

//--- design/er_fsm.sv
`timescale 1ns/100ps

module er_fsm
    import er_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      cascade_params_valid,
    input  logic      cascade_done,
    input  logic      hash_valid,
    input  logic      b2a_empty,
    input  logic      a2b_full,
    input  logic      step_done,
    input  logic      tags_match,
    output logic      clear,
    output logic      cascade_start,
    output logic      hash_start,
    output logic      ec_owns_fifo,
    output logic      finish,
    output logic      fail,
    output logic      er_parameter_valid,
    output er_phase_t phase
);

    er_state_t state;
    er_state_t next_state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ER_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ER_IDLE: begin
                if (start) begin
                    next_state = ER_RESET;
                end
            end
            ER_RESET:      next_state = ER_START;
            ER_START:      next_state = CASCADE_START;
            CASCADE_START: next_state = CASCADE_BUSY;
            CASCADE_BUSY: begin
                if (cascade_params_valid) begin
                    next_state = FRAME_PARAMETER_VALID;
                end
            end
            // parameters are in, wait for the corrected key
            FRAME_PARAMETER_VALID: begin
                if (cascade_done) begin
                    next_state = CASCADE_DONE;
                end
            end
            CASCADE_DONE:  next_state = HASHTAG_START;
            HASHTAG_START: next_state = HASHTAG_BUSY;
            HASHTAG_BUSY: begin
                if (hash_valid) begin
                    next_state = HASHTAG_VALID;
                end
            end
            HASHTAG_VALID: next_state = WAIT_BOB_HASHTAG;
            // bob's packet waiting and room to answer
            WAIT_BOB_HASHTAG: begin
                if (!b2a_empty && !a2b_full) begin
                    next_state = READ_BOB_HASHTAG;
                end
            end
            READ_BOB_HASHTAG: begin
                if (step_done) begin
                    next_state = SEND_HASHTAG_PARAMETER;
                end
            end
            SEND_HASHTAG_PARAMETER: begin
                if (step_done) begin
                    next_state = COMPARE_HASHTAG;
                end
            end
            COMPARE_HASHTAG: begin
                if (tags_match) begin
                    next_state = WRITE_RECONCILED_KEY;
                end else begin
                    next_state = ER_FAIL;
                end
            end
            WRITE_RECONCILED_KEY: begin
                if (step_done) begin
                    next_state = WRITE_DONE;
                end
            end
            WRITE_DONE: next_state = ER_DONE;
            ER_DONE:    next_state = ER_IDLE;
            ER_FAIL:    next_state = ER_IDLE;
            default:    next_state = ER_IDLE;
        endcase
    end

    // strobes straight from the state
    assign clear = (state == ER_RESET);
    assign cascade_start = (state == CASCADE_START);
    assign hash_start = (state == HASHTAG_START);
    assign ec_owns_fifo = (state == CASCADE_START) || (state == CASCADE_BUSY) ||
                          (state == FRAME_PARAMETER_VALID) || (state == CASCADE_DONE);
    assign finish = (state == ER_DONE) || (state == ER_FAIL);
    assign fail = (state == ER_FAIL);
    // parameters reported on both outcomes
    assign er_parameter_valid = finish;

    always_comb begin
        case (state)
            READ_BOB_HASHTAG:       phase = PHASE_READ;
            SEND_HASHTAG_PARAMETER: phase = PHASE_SEND;
            WRITE_RECONCILED_KEY:   phase = PHASE_WRITE;
            default:                phase = PHASE_IDLE;
        endcase
    end

endmodule

//--- design/er_pkg.sv
package er_pkg;

    // peer fifo word
    localparam int fifo_word_w = 32;
    typedef logic [fifo_word_w-1:0] fifo_word_t;

    // full hash tag and the half that goes over the link
    localparam int hashtag_w = 64;
    typedef logic [hashtag_w-1:0] hashtag_t;
    localparam int peer_tag_w = 32;
    typedef logic [peer_tag_w-1:0] peer_tag_t;

    // frame parameters from the cascade engine
    localparam int error_count_w = 12;
    typedef logic [error_count_w-1:0] error_count_t;
    localparam int leaked_info_w = 16;
    typedef logic [leaked_info_w-1:0] leaked_info_t;

    // corrected key and key memory
    localparam int key_word_w = 64;
    typedef logic [key_word_w-1:0] key_word_t;
    localparam int key_words = 8;
    typedef logic [key_words*key_word_w-1:0] corrected_key_t;
    localparam int key_addr_w = 15;
    typedef logic [key_addr_w-1:0] key_addr_t;

    // shared step counter
    localparam int step_w = 4;
    typedef logic [step_w-1:0] step_t;

    // estimate used before the first frame
    localparam error_count_t default_error_count = error_count_t'(250);

    localparam step_t read_end_step = step_t'(5);
    localparam step_t send_end_step = step_t'(5);
    localparam step_t write_end_step = step_t'(key_words + 4);

    // tag packet header fields, msb first
    localparam logic [3:0] pkt_type_target_hashtag = 4'hA;
    localparam logic [3:0] pkt_len_code = 4'h3;
    localparam logic [8:0] tag_pkt_depth = 9'd2;

    typedef enum logic [4:0] {
        ER_IDLE, ER_RESET, ER_START,
        CASCADE_START, CASCADE_BUSY, FRAME_PARAMETER_VALID, CASCADE_DONE,
        HASHTAG_START, HASHTAG_BUSY, HASHTAG_VALID,
        WAIT_BOB_HASHTAG, READ_BOB_HASHTAG, SEND_HASHTAG_PARAMETER, COMPARE_HASHTAG,
        WRITE_RECONCILED_KEY, WRITE_DONE,
        ER_DONE, ER_FAIL
    } er_state_t;

    typedef enum logic [1:0] {
        PHASE_IDLE, PHASE_READ, PHASE_SEND, PHASE_WRITE
    } er_phase_t;

endpackage
